/* include/neuron_defines.svh */
`ifndef NEURON_DEFINES_SVH
`define NEURON_DEFINES_SVH

// layer size.
`define NUM_NEURONS 4
`define NUM_INPUTS  4

// weights, potentials and model parameters share one width.
`define DATA_W 32

// wide enough to index a neuron or an input line.
`define IDX_W 2

// lif leak removes v >> LEAK_SHIFT every step.
`define LEAK_SHIFT 3

// one load cycle plus one cycle per multiplier bit.
`define MUL_CYCLES 33

`endif

/* rtl/neuron_pkg.sv */
`default_nettype none

`include "neuron_defines.svh"

package neuron_pkg;

    typedef enum logic [1:0] {
        MODEL_LIF  = 2'd0,
        MODEL_IZHI = 2'd1
    } model_e;

    // targets of a configuration write.
    typedef enum logic [2:0] {
        SEL_A  = 3'd0,
        SEL_B  = 3'd1,
        SEL_C  = 3'd2,
        SEL_D  = 3'd3,
        SEL_VT = 3'd4,
        SEL_U  = 3'd5,
        SEL_V  = 3'd6,
        SEL_W  = 3'd7 // synaptic weight, uses input_idx.
    } param_sel_e;

    typedef struct packed {
        logic               load;
        param_sel_e         sel;
        logic [`IDX_W-1:0]  neuron;
        logic [`IDX_W-1:0]  input_idx;
        logic [`DATA_W-1:0] value;
    } cfg_req_t;

    typedef struct packed {
        logic               start;
        logic [`DATA_W-1:0] current;
    } neuron_drive_t;

    typedef struct packed {
        logic               done;
        logic               spike;
        logic [`DATA_W-1:0] potential;
    } neuron_result_t;

endpackage

`default_nettype wire

/* rtl/seq_multiplier.sv */
`timescale 1ns/1ps
`default_nettype none

`include "neuron_defines.svh"

module seq_multiplier (
    input  logic               bv_done,
    input  logic               rst,
    input  logic               start,
    input  logic [`DATA_W-1:0] a,
    input  logic [`DATA_W-1:0] b,
    output logic [`DATA_W-1:0] product,
    output logic               done
);

    localparam int CNT_W = $clog2(`MUL_CYCLES);

    logic [`DATA_W-1:0] mcand;
    logic [`DATA_W-1:0] mplier;
    logic [`DATA_W-1:0] acc;
    logic [`DATA_W-1:0] acc_next;
    logic [CNT_W-1:0]   count;
    logic               busy;
    logic               last;

    assign acc_next = mplier[0] ? acc + mcand : acc;
    assign last     = busy && (count == CNT_W'(`MUL_CYCLES - 1)); // final bit this cycle.

    always_ff @(posedge bv_done) begin
        if (rst) begin
            busy  <= 1'b0;
            done  <= 1'b0;
            count <= '0;
        end else begin
            done <= last && !start;
            if (start) begin
                busy  <= 1'b1; // restarts a running multiply too.
                count <= CNT_W'(1);
            end else if (last) begin
                busy <= 1'b0;
            end else if (busy) begin
                count <= count + 1'b1;
            end
        end
    end

    // one multiplier bit per cycle, only the low word is kept.
    always_ff @(posedge bv_done) begin
        if (start) begin
            mcand  <= a;
            mplier <= b;
            acc    <= '0;
        end else if (busy) begin
            acc    <= acc_next;
            mcand  <= mcand << 1;
            mplier <= mplier >> 1;
        end
        if (last && !start) begin
            product <= acc_next;
        end
    end

endmodule

`default_nettype wire

/* rtl/potential_adder.sv */
`timescale 1ns/1ps
`default_nettype none

`include "neuron_defines.svh"

module potential_adder (
    input  logic                       bv_done,
    input  logic                       rst,
    input  neuron_pkg::model_e         model,
    input  logic                       start,
    input  logic [`DATA_W-1:0]         current,
    input  logic [`DATA_W-1:0]         decayed,
    input  logic                       cfg_load,
    input  neuron_pkg::param_sel_e     cfg_sel,
    input  logic [`DATA_W-1:0]         cfg_value,
    output neuron_pkg::neuron_result_t result
);

    import neuron_pkg::*;

    typedef enum logic [2:0] {
        ST_IDLE,
        ST_ADD,
        ST_MUL_BV,
        ST_MUL_ABV,
        ST_FINISH
    } add_state_e;

    add_state_e         state;
    logic [`DATA_W-1:0] a;
    logic [`DATA_W-1:0] b;
    logic [`DATA_W-1:0] c;
    logic [`DATA_W-1:0] d;
    logic [`DATA_W-1:0] vt;
    logic [`DATA_W-1:0] u;
    logic [`DATA_W-1:0] sum_c;
    logic [`DATA_W-1:0] sum_q;
    logic               fire;
    logic               mul_start;
    logic               mul_done;
    logic [`DATA_W-1:0] mul_a;
    logic [`DATA_W-1:0] mul_b;
    logic [`DATA_W-1:0] mul_product;

    assign sum_c = (model == MODEL_IZHI) ? current + decayed - u : current + decayed;
    assign fire  = sum_q > vt;

    // b*v is kicked off with the add, a*(bv-u) as soon as b*v is ready.
    assign mul_start = (state == ST_IDLE && start && model == MODEL_IZHI) ||
                       (state == ST_MUL_BV && mul_done);
    assign mul_a = (state == ST_MUL_BV) ? a : b;
    assign mul_b = (state == ST_MUL_BV) ? mul_product - u : decayed;

    seq_multiplier u_mul (
        .bv_done (bv_done),
        .rst     (rst),
        .start   (mul_start),
        .a       (mul_a),
        .b       (mul_b),
        .product (mul_product),
        .done    (mul_done)
    );

    always_ff @(posedge bv_done) begin
        if (rst) begin
            state <= ST_IDLE;
            sum_q <= '0;
            a     <= '0;
            b     <= '0;
            c     <= '0;
            d     <= '0;
            vt    <= '0;
            u     <= '0;
        end else begin
            if (cfg_load) begin
                case (cfg_sel)
                    SEL_A:   a  <= cfg_value;
                    SEL_B:   b  <= cfg_value;
                    SEL_C:   c  <= cfg_value;
                    SEL_D:   d  <= cfg_value;
                    SEL_VT:  vt <= cfg_value;
                    SEL_U:   u  <= cfg_value;
                    default: ; // v and weights live elsewhere.
                endcase
            end
            case (state)
                ST_IDLE: begin
                    if (start) begin
                        sum_q <= sum_c;
                        state <= ST_ADD;
                    end
                end
                ST_ADD:     state <= (model == MODEL_IZHI) ? ST_MUL_BV : ST_IDLE;
                ST_MUL_BV:  if (mul_done) state <= ST_MUL_ABV;
                ST_MUL_ABV: begin
                    if (mul_done) begin
                        u     <= fire ? u + d : mul_product; // recovery update.
                        state <= ST_FINISH;
                    end
                end
                ST_FINISH:  state <= ST_IDLE;
                default:    state <= ST_IDLE;
            endcase
        end
    end

    // lif answers straight from the registered sum.
    always_comb begin
        result.done  = (state == ST_FINISH) || (state == ST_ADD && model == MODEL_LIF);
        result.spike = fire;
        if (!fire) begin
            result.potential = sum_q;
        end else if (model == MODEL_LIF) begin
            result.potential = sum_q - vt;
        end else begin
            result.potential = c;
        end
    end

endmodule

`default_nettype wire

/* rtl/neuron_unit.sv */
`timescale 1ns/1ps
`default_nettype none

`include "neuron_defines.svh"

module neuron_unit (
    input  logic                       bv_done,
    input  logic                       rst,
    input  neuron_pkg::model_e         model,
    input  neuron_pkg::neuron_drive_t  drive,
    input  logic                       cfg_load,
    input  neuron_pkg::param_sel_e     cfg_sel,
    input  logic [`DATA_W-1:0]         cfg_value,
    output neuron_pkg::neuron_result_t result
);

    import neuron_pkg::*;

    logic [`DATA_W-1:0] v;
    logic [`DATA_W-1:0] decayed;
    logic [`DATA_W-1:0] current_q;
    logic [`DATA_W-1:0] decayed_q;
    logic               start_q;

    // izhikevich keeps v as is.
    assign decayed = (model == MODEL_LIF) ? v - (v >> `LEAK_SHIFT) : v;

    always_ff @(posedge bv_done) begin
        if (rst) begin
            start_q <= 1'b0;
            v       <= '0;
        end else begin
            start_q <= drive.start;
            if (result.done) begin
                v <= result.potential;
            end else if (cfg_load && cfg_sel == SEL_V) begin
                v <= cfg_value;
            end
        end
    end

    always_ff @(posedge bv_done) begin
        if (drive.start) begin
            current_q <= drive.current;
            decayed_q <= decayed; // held until the next step.
        end
    end

    potential_adder u_adder (
        .bv_done   (bv_done),
        .rst       (rst),
        .model     (model),
        .start     (start_q),
        .current   (current_q),
        .decayed   (decayed_q),
        .cfg_load  (cfg_load),
        .cfg_sel   (cfg_sel),
        .cfg_value (cfg_value),
        .result    (result)
    );

endmodule

`default_nettype wire

/* rtl/weight_dispatch.sv */
`timescale 1ns/1ps
`default_nettype none

`include "neuron_defines.svh"

module weight_dispatch (
    input  logic                                          bv_done,
    input  logic                                          rst,
    input  logic                                          time_step,
    input  logic [`NUM_INPUTS-1:0]                        in_spikes,
    input  neuron_pkg::cfg_req_t                          cfg,
    input  logic                                          step_done,
    output neuron_pkg::neuron_drive_t [`NUM_NEURONS-1:0]  drive,
    output logic [`NUM_NEURONS-1:0]                       cfg_load,
    output neuron_pkg::param_sel_e                        cfg_sel,
    output logic [`DATA_W-1:0]                            cfg_value
);

    import neuron_pkg::*;

    logic [`DATA_W-1:0] weights [`NUM_NEURONS][`NUM_INPUTS];
    logic [`DATA_W-1:0] current_c [`NUM_NEURONS];
    logic [`DATA_W-1:0] current_q [`NUM_NEURONS];
    logic               start_q;
    logic               busy;
    logic               accept;
    logic               cfg_ok;

    assign accept    = time_step && !busy;
    assign cfg_ok    = cfg.load && !busy; // no writes mid-step.
    assign cfg_sel   = cfg.sel;
    assign cfg_value = cfg.value;

    always_comb begin
        for (int n = 0; n < `NUM_NEURONS; n++) begin
            current_c[n] = '0;
            for (int i = 0; i < `NUM_INPUTS; i++) begin
                if (in_spikes[i]) current_c[n] = current_c[n] + weights[n][i];
            end
            cfg_load[n]      = cfg_ok && (cfg.sel != SEL_W) && (cfg.neuron == `IDX_W'(n));
            drive[n].start   = start_q;
            drive[n].current = current_q[n];
        end
    end

    always_ff @(posedge bv_done) begin
        if (rst) begin
            start_q <= 1'b0;
            busy    <= 1'b0;
            for (int n = 0; n < `NUM_NEURONS; n++) begin
                for (int i = 0; i < `NUM_INPUTS; i++) weights[n][i] <= '0;
            end
        end else begin
            start_q <= accept;
            if (accept) begin
                busy <= 1'b1;
            end else if (step_done) begin
                busy <= 1'b0;
            end
            if (cfg_ok && cfg.sel == SEL_W) weights[cfg.neuron][cfg.input_idx] <= cfg.value;
        end
    end

    always_ff @(posedge bv_done) begin
        if (accept) current_q <= current_c;
    end

endmodule

`default_nettype wire

/* rtl/spike_collector.sv */
`timescale 1ns/1ps
`default_nettype none

`include "neuron_defines.svh"

module spike_collector (
    input  logic                                          bv_done,
    input  logic                                          rst,
    input  neuron_pkg::neuron_result_t [`NUM_NEURONS-1:0] result,
    input  logic [`IDX_W-1:0]                             probe_sel,
    output logic [`NUM_NEURONS-1:0]                       out_spikes,
    output logic                                          step_done,
    output logic [`DATA_W-1:0]                            probe_potential
);

    logic [`NUM_NEURONS-1:0] seen;
    logic [`NUM_NEURONS-1:0] seen_next;
    logic [`NUM_NEURONS-1:0] spike_l;
    logic [`NUM_NEURONS-1:0] spike_next;
    logic [`DATA_W-1:0]      potential_l [`NUM_NEURONS];

    always_comb begin
        for (int n = 0; n < `NUM_NEURONS; n++) begin
            seen_next[n]  = seen[n] | result[n].done;
            spike_next[n] = result[n].done ? result[n].spike : spike_l[n];
        end
    end

    assign probe_potential = potential_l[probe_sel];

    always_ff @(posedge bv_done) begin
        if (rst) begin
            seen       <= '0;
            spike_l    <= '0;
            out_spikes <= '0;
            step_done  <= 1'b0;
            for (int n = 0; n < `NUM_NEURONS; n++) potential_l[n] <= '0;
        end else begin
            step_done <= &seen_next;
            spike_l   <= spike_next;
            if (&seen_next) begin
                seen       <= '0; // ready for the next step.
                out_spikes <= spike_next;
            end else begin
                seen <= seen_next;
            end
            for (int n = 0; n < `NUM_NEURONS; n++) begin
                if (result[n].done) potential_l[n] <= result[n].potential;
            end
        end
    end

endmodule

`default_nettype wire

/* rtl/neuron_array.sv */
`timescale 1ns/1ps
`default_nettype none

`include "neuron_defines.svh"

module neuron_array (
    input  logic                    bv_done,
    input  logic                    rst,
    input  logic                    time_step,
    input  logic [`NUM_INPUTS-1:0]  in_spikes,
    input  neuron_pkg::model_e      model,
    input  neuron_pkg::cfg_req_t    cfg,
    input  logic [`IDX_W-1:0]       probe_sel,
    output logic [`NUM_NEURONS-1:0] out_spikes,
    output logic                    step_done,
    output logic [`DATA_W-1:0]      probe_potential
);

    import neuron_pkg::*;

    neuron_drive_t  [`NUM_NEURONS-1:0] drive;
    neuron_result_t [`NUM_NEURONS-1:0] result;
    logic [`NUM_NEURONS-1:0]           cfg_load;
    param_sel_e                        cfg_sel;
    logic [`DATA_W-1:0]                cfg_value;

    weight_dispatch u_dispatch (
        .bv_done   (bv_done),
        .rst       (rst),
        .time_step (time_step),
        .in_spikes (in_spikes),
        .cfg       (cfg),
        .step_done (step_done),
        .drive     (drive),
        .cfg_load  (cfg_load),
        .cfg_sel   (cfg_sel),
        .cfg_value (cfg_value)
    );

    // all neurons start together and finish together.
    for (genvar n = 0; n < `NUM_NEURONS; n++) begin : g_neuron
        neuron_unit u_neuron (
            .bv_done   (bv_done),
            .rst       (rst),
            .model     (model),
            .drive     (drive[n]),
            .cfg_load  (cfg_load[n]),
            .cfg_sel   (cfg_sel),
            .cfg_value (cfg_value),
            .result    (result[n])
        );
    end

    spike_collector u_collector (
        .bv_done         (bv_done),
        .rst             (rst),
        .result          (result),
        .probe_sel       (probe_sel),
        .out_spikes      (out_spikes),
        .step_done       (step_done),
        .probe_potential (probe_potential)
    );

endmodule

`default_nettype wire

/* tests/neuron_array_checker.sv */
`timescale 1ns/1ps
`default_nettype none

`include "neuron_defines.svh"

module neuron_array_checker (
    input logic                    bv_done,
    input logic                    rst,
    input logic                    time_step,
    input logic                    step_done,
    input logic [`NUM_NEURONS-1:0] out_spikes
);

    int   fail_count = 0;
    logic armed; // a step was accepted and has not finished yet.

    always_ff @(posedge bv_done) begin
        if (rst) begin
            armed <= 1'b0;
        end else if (time_step && !armed) begin
            armed <= 1'b1;
        end else if (step_done) begin
            armed <= 1'b0;
        end
    end

    step_done_single: assert property (@(posedge bv_done) disable iff (rst)
        step_done |=> !step_done)
        else begin
            fail_count++;
            $error("step_done stayed high for two cycles");
        end

    step_done_armed: assert property (@(posedge bv_done) disable iff (rst)
        step_done |-> armed)
        else begin
            fail_count++;
            $error("step_done without an accepted time_step");
        end

    // spikes only move together with step_done.
    spikes_stable: assert property (@(posedge bv_done) disable iff (rst)
        !step_done |-> $stable(out_spikes))
        else begin
            fail_count++;
            $error("out_spikes changed outside step_done");
        end

endmodule

bind neuron_array neuron_array_checker u_checker (
    .bv_done    (bv_done),
    .rst        (rst),
    .time_step  (time_step),
    .step_done  (step_done),
    .out_spikes (out_spikes)
);

`default_nettype wire

/* tests/neuron_array_tb.sv */
`timescale 1ns/1ps
`default_nettype none

`include "neuron_defines.svh"

module neuron_array_tb;

    import neuron_pkg::*;

    localparam int STEP_CYCLES = 4 + 2 * `MUL_CYCLES + 8;
    localparam int CFG_CYCLES  = 400;
    localparam int RUN_LIMIT   = 16 + 60 * STEP_CYCLES + CFG_CYCLES;

    logic                    bv_done;
    logic                    rst;
    logic                    time_step;
    logic [`NUM_INPUTS-1:0]  in_spikes;
    model_e                  model;
    cfg_req_t                cfg;
    logic [`IDX_W-1:0]       probe_sel;
    logic [`NUM_NEURONS-1:0] out_spikes;
    logic                    step_done;
    logic [`DATA_W-1:0]      probe_potential;

    // reference copy of the layer state.
    logic [`DATA_W-1:0]      ref_w [`NUM_NEURONS][`NUM_INPUTS];
    logic [`DATA_W-1:0]      ref_a [`NUM_NEURONS];
    logic [`DATA_W-1:0]      ref_b [`NUM_NEURONS];
    logic [`DATA_W-1:0]      ref_c [`NUM_NEURONS];
    logic [`DATA_W-1:0]      ref_d [`NUM_NEURONS];
    logic [`DATA_W-1:0]      ref_vt [`NUM_NEURONS];
    logic [`DATA_W-1:0]      ref_u [`NUM_NEURONS];
    logic [`DATA_W-1:0]      ref_v [`NUM_NEURONS];
    logic [`NUM_NEURONS-1:0] exp_spikes;
    logic [31:0]             rng_state = 32'd4;
    int                      cycle_count = 0;

    neuron_array u_neuron_array (
        .bv_done         (bv_done),
        .rst             (rst),
        .time_step       (time_step),
        .in_spikes       (in_spikes),
        .model           (model),
        .cfg             (cfg),
        .probe_sel       (probe_sel),
        .out_spikes      (out_spikes),
        .step_done       (step_done),
        .probe_potential (probe_potential)
    );

    initial begin
        bv_done = 1'b0;
        forever #2 bv_done = ~bv_done;
    end

    always @(posedge bv_done) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= RUN_LIMIT) begin
            $display("TIMEOUT: run passed its limit of %0d cycles", RUN_LIMIT);
            $display("Errors found");
            $fatal(1);
        end
    end

    function automatic logic [31:0] next_rand();
        rng_state = rng_state * 32'd1664525 + 32'd1013904223;
        return rng_state >> 8; // low lcg bits repeat too soon.
    endfunction

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            $display("MISMATCH %s: got 0x%08h expected 0x%08h", name, got, exp);
            $display("Errors found");
            $fatal(1);
        end
    endtask

    task automatic write_cfg(input param_sel_e sel, input int neuron, input int input_idx,
                             input logic [31:0] value);
        @(negedge bv_done);
        cfg.load      = 1'b1;
        cfg.sel       = sel;
        cfg.neuron    = `IDX_W'(neuron);
        cfg.input_idx = `IDX_W'(input_idx);
        cfg.value     = value;
        @(negedge bv_done);
        cfg.load = 1'b0;
        case (sel)
            SEL_A:  ref_a[neuron] = value;
            SEL_B:  ref_b[neuron] = value;
            SEL_C:  ref_c[neuron] = value;
            SEL_D:  ref_d[neuron] = value;
            SEL_VT: ref_vt[neuron] = value;
            SEL_U:  ref_u[neuron] = value;
            SEL_V:  ref_v[neuron] = value;
            SEL_W:  ref_w[neuron][input_idx] = value;
        endcase
    endtask

    task automatic predict_step(input logic [`NUM_INPUTS-1:0] spikes);
        logic [`DATA_W-1:0] cur;
        logic [`DATA_W-1:0] sum;
        exp_spikes = '0;
        for (int n = 0; n < `NUM_NEURONS; n++) begin
            cur = '0;
            for (int i = 0; i < `NUM_INPUTS; i++) begin
                if (spikes[i]) cur = cur + ref_w[n][i];
            end
            if (model == MODEL_IZHI) begin
                sum = cur + ref_v[n] - ref_u[n];
                if (sum > ref_vt[n]) begin
                    exp_spikes[n] = 1'b1;
                    ref_v[n] = ref_c[n];
                    ref_u[n] = ref_u[n] + ref_d[n];
                end else begin
                    ref_u[n] = ref_a[n] * (ref_b[n] * ref_v[n] - ref_u[n]); // uses old v.
                    ref_v[n] = sum;
                end
            end else begin
                sum = cur + ref_v[n] - (ref_v[n] >> `LEAK_SHIFT);
                exp_spikes[n] = sum > ref_vt[n];
                ref_v[n] = exp_spikes[n] ? sum - ref_vt[n] : sum;
            end
        end
    endtask

    // extra_pulse repeats time_step on the last cycle the step is still running.
    task automatic run_step(input logic [`NUM_INPUTS-1:0] spikes, input bit extra_pulse);
        int cycles;
        int latency;
        latency = (model == MODEL_IZHI) ? 4 + 2 * `MUL_CYCLES : 4;
        predict_step(spikes);
        cycles = 0;
        @(negedge bv_done);
        time_step = 1'b1;
        in_spikes = spikes;
        while (step_done !== 1'b1) begin
            if (cycles >= STEP_CYCLES) begin
                $display("step_done missing %0d cycles after time_step", cycles);
                $display("Errors found");
                $fatal(1);
            end
            @(negedge bv_done);
            cycles++;
            time_step = extra_pulse && (cycles == latency - 1);
            in_spikes = ~spikes;
        end
        check_value("step_done latency", cycles, latency);
        check_value("out_spikes", out_spikes, exp_spikes);
        for (int n = 0; n < `NUM_NEURONS; n++) begin
            @(negedge bv_done);
            probe_sel = `IDX_W'(n);
            #1;
            check_value("step_done", step_done, 0);
            check_value($sformatf("probe_potential[%0d]", n), probe_potential, ref_v[n]);
        end
    endtask

    task automatic set_model(input model_e m);
        @(negedge bv_done);
        model = m;
    endtask

    task automatic reset_step_check();
        set_model(MODEL_LIF);
        run_step(4'b0000, 1'b0);
    endtask

    task automatic lif_integrate();
        for (int n = 0; n < `NUM_NEURONS; n++) begin
            for (int i = 0; i < `NUM_INPUTS; i++) write_cfg(SEL_W, n, i, 16 * n + i + 1);
            write_cfg(SEL_VT, n, 0, 32'd1000);
        end
        run_step(4'b0101, 1'b0);
        run_step(4'b1011, 1'b1);
    endtask

    task automatic lif_spike();
        write_cfg(SEL_VT, 2, 0, 32'd50); // only neuron 2 crosses.
        run_step(4'b1111, 1'b0);
    endtask

    task automatic izhi_below_threshold();
        set_model(MODEL_IZHI);
        for (int n = 0; n < `NUM_NEURONS; n++) begin
            write_cfg(SEL_A, n, 0, n + 2);
            write_cfg(SEL_B, n, 0, n + 3);
            write_cfg(SEL_U, n, 0, 7 * (n + 1));
            write_cfg(SEL_V, n, 0, 500 * (n + 1));
            write_cfg(SEL_VT, n, 0, 32'hffff_ffff);
        end
        run_step(4'b0011, 1'b0);
        run_step(4'b0000, 1'b0);
    endtask

    task automatic izhi_spike();
        write_cfg(SEL_V, 1, 0, 32'h1000);
        write_cfg(SEL_U, 1, 0, 32'h10);
        write_cfg(SEL_VT, 1, 0, 32'h800);
        write_cfg(SEL_C, 1, 0, 32'h40);
        write_cfg(SEL_D, 1, 0, 32'h25);
        run_step(4'b1111, 1'b0);
        run_step(4'b0000, 1'b0);
    endtask

    task automatic random_lif_run();
        set_model(MODEL_LIF);
        for (int n = 0; n < `NUM_NEURONS; n++) write_cfg(SEL_V, n, 0, 0);
        for (int s = 0; s < 40; s++) begin
            if (s % 10 == 0) begin
                for (int n = 0; n < `NUM_NEURONS; n++) begin
                    for (int i = 0; i < `NUM_INPUTS; i++) begin
                        write_cfg(SEL_W, n, i, next_rand() % 256);
                    end
                    write_cfg(SEL_VT, n, 0, 100 + next_rand() % 700);
                end
            end
            run_step(`NUM_INPUTS'(next_rand() % 16), 1'b0);
        end
    endtask

    initial begin
        rst       = 1'b1;
        time_step = 1'b0;
        in_spikes = '0;
        model     = MODEL_LIF;
        cfg       = '0;
        probe_sel = '0;
        for (int n = 0; n < `NUM_NEURONS; n++) begin
            for (int i = 0; i < `NUM_INPUTS; i++) ref_w[n][i] = '0;
            ref_a[n]  = '0;
            ref_b[n]  = '0;
            ref_c[n]  = '0;
            ref_d[n]  = '0;
            ref_vt[n] = '0;
            ref_u[n]  = '0;
            ref_v[n]  = '0;
        end
        repeat (16) @(negedge bv_done);
        rst = 1'b0;
        reset_step_check();
        lif_integrate();
        lif_spike();
        izhi_below_threshold();
        izhi_spike();
        random_lif_run();
        if (u_neuron_array.u_checker.fail_count != 0) begin
            $display("checker saw %0d assertion failures", u_neuron_array.u_checker.fail_count);
            $display("Errors found");
            $fatal(1);
        end else begin
            $display("No errors");
            $finish;
        end
    end

endmodule

`default_nettype wire

/* sim.f */
+incdir+include
rtl/neuron_pkg.sv
rtl/seq_multiplier.sv
rtl/potential_adder.sv
rtl/neuron_unit.sv
rtl/weight_dispatch.sv
rtl/spike_collector.sv
rtl/neuron_array.sv
tests/neuron_array_checker.sv
tests/neuron_array_tb.sv
